// ==== filelist.f ====
rtl/ex_pkg.sv
rtl/operand_forward.sv
rtl/alu.sv
rtl/branch_resolve.sv
rtl/execute.sv
rtl/ex_stage.sv
dv/ex_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f filelist.f \
    --top-module ex_stage_tb -o ex_stage_tb

# The run may exit nonzero on failure, the pass line decides
out=$(./obj_dir/ex_stage_tb) || true
echo "$out"

if echo "$out" | grep -q "^sim passed$"; then
    exit 0
else
    exit 1
fi

// ==== dv/ex_stage_tb.sv ====
`timescale 1ns/1ps

module ex_stage_tb;

    localparam int XLEN       = 32;
    localparam int AW         = ex_pkg::REG_AW;
    localparam int SHW        = $clog2(XLEN);
    localparam int PERIOD     = 4;
    localparam int RST_CYCLES = 5;
    localparam int N_ALU      = 400;
    localparam int N_FWD      = 300;
    localparam int N_BR       = 400;
    localparam int N_OTH      = 300;
    // Every phase plus reset and a few spare cycles, with a margin of two
    localparam int TIMEOUT_NS = (RST_CYCLES + N_ALU + N_FWD + N_BR + N_OTH + 4) * PERIOD * 2;

    logic                        clk = 1'b0;
    logic                        rst;
    logic [XLEN-1:0]             id_rs1_value;
    logic [XLEN-1:0]             id_rs2_value;
    logic [AW-1:0]               id_rs1_addr;
    logic [AW-1:0]               id_rs2_addr;
    logic [XLEN-1:0]             id_imm;
    logic [XLEN-1:0]             id_pc;
    logic [ex_pkg::CLS_W-1:0]    id_class;
    logic                        id_alu_src;
    logic [ex_pkg::ALU_FN_W-1:0] id_alu_fn;
    logic                        id_branch_en;
    logic [ex_pkg::BR_FN_W-1:0]  id_branch_fn;
    logic                        id_mem_write;
    logic                        id_mem_read;
    logic                        id_reg_write;
    logic [AW-1:0]               id_reg_dest;
    logic                        id_mem_to_reg;
    logic                        fwd_mem_reg_write;
    logic [AW-1:0]               fwd_mem_reg_dest;
    logic [XLEN-1:0]             fwd_mem_value;
    logic                        fwd_wb_reg_write;
    logic [AW-1:0]               fwd_wb_reg_dest;
    logic [XLEN-1:0]             fwd_wb_value;
    logic                        mem_write;
    logic                        mem_read;
    logic                        reg_write;
    logic [AW-1:0]               reg_dest;
    logic                        mem_to_reg;
    logic [XLEN-1:0]             store_data;
    logic [XLEN-1:0]             branch_target;
    logic [XLEN-1:0]             result;
    logic                        branch_taken;

    // Expected outputs of the instruction currently in EX
    logic [XLEN-1:0] exp_result;
    logic [XLEN-1:0] exp_store;
    logic [XLEN-1:0] exp_target;
    logic            exp_taken;
    logic            exp_mem_write;
    logic            exp_mem_read;
    logic            exp_reg_write;
    logic [AW-1:0]   exp_reg_dest;
    logic            exp_mem_to_reg;
    bit              pending;

    // Classes that take ALU_ADD, plus the unused code 110
    logic [ex_pkg::CLS_W-1:0] other_cls [6] = '{ex_pkg::CLS_MEM, ex_pkg::CLS_LUI,
        ex_pkg::CLS_AUIPC, ex_pkg::CLS_JAL, ex_pkg::CLS_JALR, 3'b110};

    ex_stage #(
        .XLEN (XLEN)
    ) uut (.*);

    always #(PERIOD / 2) clk = ~clk;

    task automatic check_word(input string name, input logic [XLEN-1:0] exp_v,
                              input logic [XLEN-1:0] act_v);
        if (act_v !== exp_v)
        begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
            $display("sim failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_addr(input string name, input logic [AW-1:0] exp_v,
                              input logic [AW-1:0] act_v);
        if (act_v !== exp_v)
        begin
            $display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, exp_v, act_v);
            $display("sim failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v)
        begin
            $display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp_v, act_v);
            $display("sim failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // A write to x0 never matches since the source address must be nonzero
    function automatic logic [XLEN-1:0] fwd_model(input logic [XLEN-1:0] rf,
                                                  input logic [AW-1:0] addr);
        if (addr == '0)
            return rf;
        if (fwd_mem_reg_write && fwd_mem_reg_dest == addr)
            return fwd_mem_value;   // Youngest write first
        if (fwd_wb_reg_write && fwd_wb_reg_dest == addr)
            return fwd_wb_value;
        return rf;
    endfunction

    function automatic logic [XLEN-1:0] alu_model(input logic [ex_pkg::ALU_FN_W-1:0] fn,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        logic [XLEN-1:0] r;
        r = '0;
        case (fn)
            ex_pkg::ALU_ADD:  r = a + b;
            ex_pkg::ALU_SUB:  r = a - b;
            ex_pkg::ALU_SLL:  r = a << b[SHW-1:0];
            ex_pkg::ALU_SLT:  r[0] = $signed(a) < $signed(b);
            ex_pkg::ALU_SLTU: r[0] = a < b;
            ex_pkg::ALU_XOR:  r = a ^ b;
            ex_pkg::ALU_SRL:  r = a >> b[SHW-1:0];
            ex_pkg::ALU_SRA:  r = $signed(a) >>> b[SHW-1:0];
            ex_pkg::ALU_OR:   r = a | b;
            ex_pkg::ALU_AND:  r = a & b;
            default:          r = '0;
        endcase
        return r;
    endfunction

    function automatic logic branch_model(input logic [ex_pkg::CLS_W-1:0] cls, input logic en,
                                          input logic [ex_pkg::BR_FN_W-1:0] fn,
                                          input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        logic cond;
        case (fn)
            ex_pkg::BR_EQ:  cond = (a == b);
            ex_pkg::BR_NE:  cond = (a != b);
            ex_pkg::BR_LT:  cond = ($signed(a) < $signed(b));
            ex_pkg::BR_GE:  cond = ($signed(a) >= $signed(b));
            ex_pkg::BR_LTU: cond = (a < b);
            ex_pkg::BR_GEU: cond = (a >= b);
            default:        cond = 1'b0;
        endcase
        return en && (cls == ex_pkg::CLS_BRANCH) && cond;
    endfunction

    task automatic check_outputs();
        check_word("result", exp_result, result);
        check_word("store_data", exp_store, store_data);
        check_word("branch_target", exp_target, branch_target);
        check_bit("branch_taken", exp_taken, branch_taken);
        check_bit("mem_write", exp_mem_write, mem_write);
        check_bit("mem_read", exp_mem_read, mem_read);
        check_bit("reg_write", exp_reg_write, reg_write);
        check_addr("reg_dest", exp_reg_dest, reg_dest);
        check_bit("mem_to_reg", exp_mem_to_reg, mem_to_reg);
    endtask

    // Checks the previous instruction, then drives a new one on the falling edge
    task automatic drive_instr(input logic [ex_pkg::CLS_W-1:0] cls,
                               input logic [ex_pkg::ALU_FN_W-1:0] fn,
                               input int unsigned span, input bit fwd_en, input bit same_src);
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        @(negedge clk);
        if (pending)
            check_outputs();
        id_class          = cls;
        id_alu_fn         = fn;
        id_rs1_value      = XLEN'($urandom);
        id_rs2_value      = XLEN'($urandom);
        id_rs1_addr       = AW'($urandom_range(0, span));
        id_rs2_addr       = AW'($urandom_range(0, span));
        if (same_src)
        begin
            id_rs2_value = id_rs1_value;    // Same source, so operands compare equal
            id_rs2_addr  = id_rs1_addr;
        end
        id_imm            = XLEN'($urandom);
        id_pc             = XLEN'($urandom) & ~XLEN'(3);
        id_alu_src        = 1'($urandom_range(0, 1));
        id_branch_en      = 1'($urandom_range(0, 1));
        id_branch_fn      = ex_pkg::BR_FN_W'($urandom_range(0, 7));
        id_mem_write      = 1'($urandom_range(0, 1));
        id_mem_read       = 1'($urandom_range(0, 1));
        id_reg_write      = 1'($urandom_range(0, 1));
        id_reg_dest       = AW'($urandom);
        id_mem_to_reg     = 1'($urandom_range(0, 1));
        fwd_mem_reg_write = fwd_en && ($urandom_range(0, 1) == 1);
        fwd_mem_reg_dest  = AW'($urandom_range(0, span));
        fwd_mem_value     = XLEN'($urandom);
        fwd_wb_reg_write  = fwd_en && ($urandom_range(0, 1) == 1);
        fwd_wb_reg_dest   = AW'($urandom_range(0, span));
        fwd_wb_value      = XLEN'($urandom);

        rs1 = fwd_model(id_rs1_value, id_rs1_addr);
        rs2 = fwd_model(id_rs2_value, id_rs2_addr);
        case (cls)
            ex_pkg::CLS_MEM:
            begin
                a = rs1;
                b = id_imm;
            end
            ex_pkg::CLS_BRANCH:
            begin
                a = rs1;
                b = rs2;
            end
            ex_pkg::CLS_ALU:
            begin
                a = rs1;
                b = id_alu_src ? id_imm : rs2;
            end
            ex_pkg::CLS_LUI:
            begin
                a = id_imm;
                b = '0;
            end
            ex_pkg::CLS_AUIPC, ex_pkg::CLS_JAL:
            begin
                a = id_pc;
                b = id_imm;
            end
            ex_pkg::CLS_JALR:
            begin
                a = rs1;
                b = id_imm;
            end
            default:
            begin
                a = '0;
                b = '0;
            end
        endcase
        exp_result     = alu_model(fn, a, b);
        exp_taken      = branch_model(cls, id_branch_en, id_branch_fn, rs1, rs2);
        exp_store      = rs2;
        exp_target     = id_pc + id_imm;
        exp_mem_write  = id_mem_write;
        exp_mem_read   = id_mem_read;
        exp_reg_write  = id_reg_write;
        exp_reg_dest   = id_reg_dest;
        exp_mem_to_reg = id_mem_to_reg;
        pending        = 1'b1;
    endtask

    initial
    begin
        #(TIMEOUT_NS);
        $display("Watchdog expired, the simulation hung");
        $display("sim failed");
        $fatal(1, "Timeout");
    end

    initial
    begin
        void'($urandom(32'h8b57_3357));
        rst               = 1'b1;
        id_rs1_value      = '0;
        id_rs2_value      = '0;
        id_rs1_addr       = '0;
        id_rs2_addr       = '0;
        id_imm            = '0;
        id_pc             = '0;
        id_class          = ex_pkg::CLS_MEM;
        id_alu_src        = 1'b0;
        id_alu_fn         = ex_pkg::ALU_ADD;
        id_branch_en      = 1'b0;
        id_branch_fn      = ex_pkg::BR_EQ;
        id_mem_write      = 1'b0;
        id_mem_read       = 1'b0;
        id_reg_write      = 1'b0;
        id_reg_dest       = '0;
        id_mem_to_reg     = 1'b0;
        fwd_mem_reg_write = 1'b0;
        fwd_mem_reg_dest  = '0;
        fwd_mem_value     = '0;
        fwd_wb_reg_write  = 1'b0;
        fwd_wb_reg_dest   = '0;
        fwd_wb_value      = '0;
        pending           = 1'b0;

        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // No instruction sampled yet
        check_bit("mem_write after reset", 1'b0, mem_write);
        check_bit("mem_read after reset", 1'b0, mem_read);
        check_bit("reg_write after reset", 1'b0, reg_write);
        check_bit("branch_taken after reset", 1'b0, branch_taken);

        // Codes 10 to 15 are undefined, operands straight from the register file
        repeat (N_ALU) drive_instr(ex_pkg::CLS_ALU, 5'($urandom_range(0, 15)), 31, 1'b0, 1'b0);
        // Narrow address range, so matches and x0 are frequent
        repeat (N_FWD) drive_instr(ex_pkg::CLS_ALU, 5'($urandom_range(0, 9)), 3, 1'b1, 1'b0);
        repeat (N_BR) drive_instr(ex_pkg::CLS_BRANCH, 5'($urandom_range(0, 9)), 31, 1'b1,
                                  1'($urandom_range(0, 1)));
        repeat (N_OTH) drive_instr(other_cls[$urandom_range(0, 5)], ex_pkg::ALU_ADD, 7, 1'b1,
                                   1'b0);
        @(negedge clk);
        check_outputs();    // Last instruction

        $display("sim passed");
        $finish;
    end

endmodule

// ==== rtl/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage #(
    parameter int XLEN = 32
) (
    input  logic                        clk,
    input  logic                        rst,

    input  logic [XLEN-1:0]             id_rs1_value,
    input  logic [XLEN-1:0]             id_rs2_value,
    input  logic [ex_pkg::REG_AW-1:0]   id_rs1_addr,
    input  logic [ex_pkg::REG_AW-1:0]   id_rs2_addr,
    input  logic [XLEN-1:0]             id_imm,
    input  logic [XLEN-1:0]             id_pc,
    input  logic [ex_pkg::CLS_W-1:0]    id_class,
    input  logic                        id_alu_src,
    input  logic [ex_pkg::ALU_FN_W-1:0] id_alu_fn,
    input  logic                        id_branch_en,
    input  logic [ex_pkg::BR_FN_W-1:0]  id_branch_fn,
    input  logic                        id_mem_write,
    input  logic                        id_mem_read,
    input  logic                        id_reg_write,
    input  logic [ex_pkg::REG_AW-1:0]   id_reg_dest,
    input  logic                        id_mem_to_reg,

    // Pending writes from later stages
    input  logic                        fwd_mem_reg_write,
    input  logic [ex_pkg::REG_AW-1:0]   fwd_mem_reg_dest,
    input  logic [XLEN-1:0]             fwd_mem_value,
    input  logic                        fwd_wb_reg_write,
    input  logic [ex_pkg::REG_AW-1:0]   fwd_wb_reg_dest,
    input  logic [XLEN-1:0]             fwd_wb_value,

    output logic                        mem_write,
    output logic                        mem_read,
    output logic                        reg_write,
    output logic [ex_pkg::REG_AW-1:0]   reg_dest,
    output logic                        mem_to_reg,
    output logic [XLEN-1:0]             store_data,
    output logic [XLEN-1:0]             branch_target,
    output logic [XLEN-1:0]             result,
    output logic                        branch_taken
);

    logic [XLEN-1:0] rs1_fwd;
    logic [XLEN-1:0] rs2_fwd;

    operand_forward #(
        .XLEN (XLEN)
    ) u_fwd_rs1 (
        .rf_value      (id_rs1_value),
        .addr          (id_rs1_addr),
        .mem_reg_write (fwd_mem_reg_write),
        .mem_reg_dest  (fwd_mem_reg_dest),
        .mem_value     (fwd_mem_value),
        .wb_reg_write  (fwd_wb_reg_write),
        .wb_reg_dest   (fwd_wb_reg_dest),
        .wb_value      (fwd_wb_value),
        .value         (rs1_fwd)
    );

    operand_forward #(
        .XLEN (XLEN)
    ) u_fwd_rs2 (
        .rf_value      (id_rs2_value),
        .addr          (id_rs2_addr),
        .mem_reg_write (fwd_mem_reg_write),
        .mem_reg_dest  (fwd_mem_reg_dest),
        .mem_value     (fwd_mem_value),
        .wb_reg_write  (fwd_wb_reg_write),
        .wb_reg_dest   (fwd_wb_reg_dest),
        .wb_value      (fwd_wb_value),
        .value         (rs2_fwd)
    );

    execute #(
        .XLEN (XLEN)
    ) u_execute (
        .clk           (clk),
        .rst           (rst),
        .id_imm        (id_imm),
        .id_pc         (id_pc),
        .id_class      (id_class),
        .id_alu_src    (id_alu_src),
        .id_alu_fn     (id_alu_fn),
        .id_branch_en  (id_branch_en),
        .id_branch_fn  (id_branch_fn),
        .id_mem_write  (id_mem_write),
        .id_mem_read   (id_mem_read),
        .id_reg_write  (id_reg_write),
        .id_reg_dest   (id_reg_dest),
        .id_mem_to_reg (id_mem_to_reg),
        .rs1_fwd       (rs1_fwd),
        .rs2_fwd       (rs2_fwd),
        .mem_write     (mem_write),
        .mem_read      (mem_read),
        .reg_write     (reg_write),
        .reg_dest      (reg_dest),
        .mem_to_reg    (mem_to_reg),
        .store_data    (store_data),
        .branch_target (branch_target),
        .result        (result),
        .branch_taken  (branch_taken)
    );

endmodule

// ==== rtl/execute.sv ====
`timescale 1ns/1ps

module execute #(
    parameter int XLEN = 32
) (
    input  logic                        clk,
    input  logic                        rst,

    // Decode side
    input  logic [XLEN-1:0]             id_imm,
    input  logic [XLEN-1:0]             id_pc,
    input  logic [ex_pkg::CLS_W-1:0]    id_class,
    input  logic                        id_alu_src,     // Use imm as second operand
    input  logic [ex_pkg::ALU_FN_W-1:0] id_alu_fn,
    input  logic                        id_branch_en,
    input  logic [ex_pkg::BR_FN_W-1:0]  id_branch_fn,
    input  logic                        id_mem_write,
    input  logic                        id_mem_read,
    input  logic                        id_reg_write,
    input  logic [ex_pkg::REG_AW-1:0]   id_reg_dest,
    input  logic                        id_mem_to_reg,

    // Operands after forwarding
    input  logic [XLEN-1:0]             rs1_fwd,
    input  logic [XLEN-1:0]             rs2_fwd,

    output logic                        mem_write,
    output logic                        mem_read,
    output logic                        reg_write,
    output logic [ex_pkg::REG_AW-1:0]   reg_dest,
    output logic                        mem_to_reg,
    output logic [XLEN-1:0]             store_data,
    output logic [XLEN-1:0]             branch_target,
    output logic [XLEN-1:0]             result,
    output logic                        branch_taken
);

    // ID/EX register contents
    logic [XLEN-1:0]             rs1_q;
    logic [XLEN-1:0]             rs2_q;
    logic [XLEN-1:0]             imm_q;
    logic [XLEN-1:0]             pc_q;
    logic [ex_pkg::CLS_W-1:0]    class_q;
    logic                        alu_src_q;
    logic [ex_pkg::ALU_FN_W-1:0] alu_fn_q;
    logic                        branch_en_q;
    logic [ex_pkg::BR_FN_W-1:0]  branch_fn_q;

    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic            eq;
    logic            lt;
    logic            ltu;
    logic            is_branch;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rs1_q         <= '0;
            rs2_q         <= '0;
            imm_q         <= '0;
            pc_q          <= '0;
            class_q       <= ex_pkg::CLS_MEM;
            alu_src_q     <= 1'b0;
            alu_fn_q      <= '0;
            branch_en_q   <= 1'b0;
            branch_fn_q   <= '0;
            mem_write     <= 1'b0;
            mem_read      <= 1'b0;
            reg_write     <= 1'b0;
            reg_dest      <= '0;
            mem_to_reg    <= 1'b0;
            branch_target <= '0;
        end
        else
        begin
            rs1_q         <= rs1_fwd;
            rs2_q         <= rs2_fwd;
            imm_q         <= id_imm;
            pc_q          <= id_pc;
            class_q       <= id_class;
            alu_src_q     <= id_alu_src;
            alu_fn_q      <= id_alu_fn;
            branch_en_q   <= id_branch_en;
            branch_fn_q   <= id_branch_fn;
            mem_write     <= id_mem_write;
            mem_read      <= id_mem_read;
            reg_write     <= id_reg_write;
            reg_dest      <= id_reg_dest;
            mem_to_reg    <= id_mem_to_reg;
            branch_target <= id_pc + id_imm;    // Computed ahead of the ALU
        end
    end

    assign store_data = rs2_q;  // Store value after forwarding

    // Operand selection by instruction class
    always_comb
    begin
        case (class_q)
            ex_pkg::CLS_MEM:
            begin
                alu_a = rs1_q;
                alu_b = imm_q;
            end
            ex_pkg::CLS_BRANCH:
            begin
                alu_a = rs1_q;
                alu_b = rs2_q;
            end
            ex_pkg::CLS_ALU:
            begin
                alu_a = rs1_q;
                alu_b = alu_src_q ? imm_q : rs2_q;
            end
            ex_pkg::CLS_LUI:
            begin
                alu_a = imm_q;
                alu_b = '0;
            end
            ex_pkg::CLS_AUIPC, ex_pkg::CLS_JAL:
            begin
                alu_a = pc_q;
                alu_b = imm_q;
            end
            ex_pkg::CLS_JALR:
            begin
                alu_a = rs1_q;  // Jump target is rs1 + imm
                alu_b = imm_q;
            end
            default:
            begin
                alu_a = '0;
                alu_b = '0;
            end
        endcase
    end

    alu #(
        .XLEN (XLEN)
    ) u_alu (
        .fn     (alu_fn_q),
        .a      (alu_a),
        .b      (alu_b),
        .result (result),
        .eq     (eq),
        .lt     (lt),
        .ltu    (ltu)
    );

    // Branch enable only counts for branch-class instructions
    assign is_branch = branch_en_q && (class_q == ex_pkg::CLS_BRANCH);

    branch_resolve u_branch_resolve (
        .branch_en (is_branch),
        .fn        (branch_fn_q),
        .eq        (eq),
        .lt        (lt),
        .ltu       (ltu),
        .taken     (branch_taken)
    );

endmodule

// ==== rtl/branch_resolve.sv ====
`timescale 1ns/1ps

module branch_resolve (
    input  logic                       branch_en,  // Already qualified by class
    input  logic [ex_pkg::BR_FN_W-1:0] fn,
    input  logic                       eq,
    input  logic                       lt,
    input  logic                       ltu,
    output logic                       taken
);

    logic cond;

    // The low funct3 bit inverts the base condition
    always_comb
    begin
        case (fn)
            ex_pkg::BR_EQ:
                cond = eq;
            ex_pkg::BR_NE:
                cond = !eq;
            ex_pkg::BR_LT:
                cond = lt;
            ex_pkg::BR_GE:
                cond = !lt;
            ex_pkg::BR_LTU:
                cond = ltu;
            ex_pkg::BR_GEU:
                cond = !ltu;
            default:
                cond = 1'b0;    // 010 and 011 are not branches
        endcase
    end

    assign taken = branch_en && cond;

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu #(
    parameter int XLEN = 32
) (
    input  logic [ex_pkg::ALU_FN_W-1:0] fn,
    input  logic [XLEN-1:0]             a,
    input  logic [XLEN-1:0]             b,
    output logic [XLEN-1:0]             result,
    output logic                        eq,     // a == b
    output logic                        lt,     // a < b, signed
    output logic                        ltu     // a < b, unsigned
);

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0] shamt;

    assign shamt = b[SHW-1:0];  // Only the low bits of b shift

    // Compare flags do not depend on fn
    // Branches and SLT/SLTU both use them
    assign eq  = (a == b);
    assign lt  = ($signed(a) < $signed(b));
    assign ltu = (a < b);

    always_comb
    begin
        case (fn)
            ex_pkg::ALU_ADD:
                result = a + b;
            ex_pkg::ALU_SUB:
                result = a - b;
            ex_pkg::ALU_SLL:
                result = a << shamt;
            ex_pkg::ALU_SLT:
                result = {{(XLEN-1){1'b0}}, lt};
            ex_pkg::ALU_SLTU:
                result = {{(XLEN-1){1'b0}}, ltu};
            ex_pkg::ALU_XOR:
                result = a ^ b;
            ex_pkg::ALU_SRL:
                result = a >> shamt;
            ex_pkg::ALU_SRA:
                result = $unsigned($signed(a) >>> shamt);  // Sign fill
            ex_pkg::ALU_OR:
                result = a | b;
            ex_pkg::ALU_AND:
                result = a & b;
            default:
                result = '0;    // Undefined code
        endcase
    end

endmodule

// ==== rtl/operand_forward.sv ====
`timescale 1ns/1ps

module operand_forward #(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0]          rf_value,      // Value read in decode
    input  logic [ex_pkg::REG_AW-1:0] addr,         // Source register address

    input  logic                      mem_reg_write,
    input  logic [ex_pkg::REG_AW-1:0] mem_reg_dest,
    input  logic [XLEN-1:0]           mem_value,

    input  logic                      wb_reg_write,
    input  logic [ex_pkg::REG_AW-1:0] wb_reg_dest,
    input  logic [XLEN-1:0]           wb_value,

    output logic [XLEN-1:0]           value
);

    logic mem_hit;
    logic wb_hit;

    // x0 is hardwired, so a pending write to it never counts
    assign mem_hit = mem_reg_write && (mem_reg_dest != '0) && (mem_reg_dest == addr);
    assign wb_hit  = wb_reg_write && (wb_reg_dest != '0) && (wb_reg_dest == addr);

    // Younger instruction in EX/MEM wins over MEM/WB
    always_comb
    begin
        if (mem_hit)
        begin
            value = mem_value;
        end
        else if (wb_hit)
        begin
            value = wb_value;
        end
        else
        begin
            value = rf_value;   // No pending write
        end
    end

endmodule

// ==== rtl/ex_pkg.sv ====
package ex_pkg;

    // Register file address width
    localparam int REG_AW = 5;

    // Field widths of the decoded control words
    localparam int CLS_W    = 3;
    localparam int ALU_FN_W = 5;
    localparam int BR_FN_W  = 3;

    // Instruction class, selects the ALU operands
    localparam logic [CLS_W-1:0] CLS_MEM    = 3'b000; // Load/store address
    localparam logic [CLS_W-1:0] CLS_BRANCH = 3'b001;
    localparam logic [CLS_W-1:0] CLS_ALU    = 3'b010; // R-type and I-type
    localparam logic [CLS_W-1:0] CLS_JAL    = 3'b011;
    localparam logic [CLS_W-1:0] CLS_LUI    = 3'b100;
    localparam logic [CLS_W-1:0] CLS_AUIPC  = 3'b101;
    localparam logic [CLS_W-1:0] CLS_JALR   = 3'b111;

    // ALU function codes
    localparam logic [ALU_FN_W-1:0] ALU_ADD  = 5'd0;
    localparam logic [ALU_FN_W-1:0] ALU_SUB  = 5'd1;
    localparam logic [ALU_FN_W-1:0] ALU_SLL  = 5'd2;
    localparam logic [ALU_FN_W-1:0] ALU_SLT  = 5'd3;
    localparam logic [ALU_FN_W-1:0] ALU_SLTU = 5'd4;
    localparam logic [ALU_FN_W-1:0] ALU_XOR  = 5'd5;
    localparam logic [ALU_FN_W-1:0] ALU_SRL  = 5'd6;
    localparam logic [ALU_FN_W-1:0] ALU_SRA  = 5'd7;
    localparam logic [ALU_FN_W-1:0] ALU_OR   = 5'd8;
    localparam logic [ALU_FN_W-1:0] ALU_AND  = 5'd9;

    // Branch functions, same encoding as funct3
    // 3'b010 and 3'b011 are not branches and never taken
    localparam logic [BR_FN_W-1:0] BR_EQ  = 3'b000;
    localparam logic [BR_FN_W-1:0] BR_NE  = 3'b001;
    localparam logic [BR_FN_W-1:0] BR_LT  = 3'b100;
    localparam logic [BR_FN_W-1:0] BR_GE  = 3'b101;
    localparam logic [BR_FN_W-1:0] BR_LTU = 3'b110;
    localparam logic [BR_FN_W-1:0] BR_GEU = 3'b111;

endpackage
